//--- dv/irq_subsys_stim.txt
# test op addr data expect, all but test in hex
# W expect=error flag, R/E expect=read data, S data=sources, I expect={timer,soft,ext}, D data=cycles
1 I 0000 00000000 00000000
1 R 0008 00000000 ffffffff
1 R 000c 00000000 ffffffff
1 W 000c 0000abcd 00000000
1 R 000c 00000000 0000abcd
1 W 1004 0000000f 00000000
1 R 1004 00000000 00000007
1 W 1100 ffffffff 00000000
1 R 1100 00000000 0000001e
1 W 1200 0000000a 00000000
1 R 1200 00000000 00000002
2 E 3000 00000000 00000000
2 W 3008 00000055 00000001
2 R 0008 00000000 ffffffff
3 W 0010 00000000 00000000
3 W 0014 00000000 00000000
3 W 000c 00000000 00000000
3 W 0008 000000c8 00000000
3 D 0000 0000000a 00000000
3 I 0000 00000000 00000000
3 D 0000 000000fa 00000000
3 I 0000 00000000 00000004
3 W 0008 ffffffff 00000000
3 I 0000 00000000 00000000
4 W 0000 00000001 00000000
4 I 0000 00000000 00000002
4 W 0000 00000000 00000000
4 I 0000 00000000 00000000
5 W 1004 00000002 00000000
5 W 1008 00000005 00000000
5 W 100c 00000005 00000000
5 W 1100 0000000e 00000000
5 W 1200 00000001 00000000
5 S 0000 00000007 00000000
5 D 0000 00000002 00000000
5 I 0000 00000000 00000001
5 R 1204 00000000 00000002
5 S 0000 00000005 00000000
5 W 1204 00000002 00000000
5 R 1204 00000000 00000003
5 S 0000 00000001 00000000
5 W 1204 00000003 00000000
5 R 1204 00000000 00000001
5 S 0000 00000000 00000000
5 W 1204 00000001 00000000
5 R 1204 00000000 00000000
5 I 0000 00000000 00000000
6 W 1200 00000005 00000000
6 S 0000 00000002 00000000
6 D 0000 00000002 00000000
6 I 0000 00000000 00000000
6 R 1204 00000000 00000000
6 R 1080 00000000 00000004
6 W 1100 00000000 00000000
6 W 1200 00000001 00000000
6 I 0000 00000000 00000000
6 R 1204 00000000 00000000
6 W 1100 00000004 00000000
6 I 0000 00000000 00000001

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- dv/tb_irq_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_irq_subsys;

    localparam string STIM_FILE       = "dv/irq_subsys_stim.txt";
    localparam int    SEED            = 52;
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    TIMEOUT_MARGIN  = 100;
    localparam int    RESET_CYCLES    = 5;
    localparam int    DRIVE_DLY       = 1;     // ns after the rising edge
    localparam int    SRC_BITS        = 4;

    logic                 clk;
    logic                 arst_n;
    logic                 host_req;
    logic                 host_we;
    logic [15:0]          host_addr;
    logic [31:0]          host_wdata;
    logic                 host_ack;
    logic [31:0]          host_rdata;
    logic                 host_err;
    logic [SRC_BITS-1:0]  irq_src;
    logic                 irq_timer;
    logic                 irq_soft;
    logic                 irq_ext;

    // One entry per stim line
    int                   stim_test[$];
    logic [7:0]           stim_op[$];
    logic [15:0]          stim_addr[$];
    logic [31:0]          stim_data[$];
    logic [31:0]          stim_exp[$];

    int                   errors;
    int                   checks;
    int                   test_errors;
    int                   test_checks;
    int                   tests_run;
    int                   watchdog_cycles = 0;

    tb_clk_gen #(.PERIOD_NS(4)) i_clk_gen (.clk_o(clk));

    irq_subsys_top i_dut (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .host_err_o   (host_err),
        .irq_src_i    (irq_src),
        .irq_timer_o  (irq_timer),
        .irq_soft_o   (irq_soft),
        .irq_ext_o    (irq_ext)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Full four-phase handshake, then a short random idle gap
    task automatic host_access(input logic we, input logic [15:0] addr,
                               input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        int gap;
        host_addr  = addr;
        host_wdata = wdata;
        host_we    = we;
        host_req   = 1'b1;
        next_edge();
        while (!host_ack) begin
            next_edge();
        end
        rdata    = host_rdata;
        err      = host_err;
        host_req = 1'b0;
        next_edge();
        while (host_ack) begin
            next_edge();
        end
        gap = int'($urandom % 4);
        repeat (gap) next_edge();
    endtask

    task automatic run_op(input int idx);
        logic [31:0] rdata;
        logic        err;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        addr = stim_addr[idx];
        data = stim_data[idx];
        expv = stim_exp[idx];
        case (stim_op[idx])
            "W": begin
                host_access(1'b1, addr, data, rdata, err);
                check_value({31'd0, err}, expv, $sformatf("error flag of write to 0x%04h", addr));
            end
            "R": begin
                host_access(1'b0, addr, 32'd0, rdata, err);
                check_value({31'd0, err}, 32'd0, $sformatf("error flag of read from 0x%04h", addr));
                check_value(rdata, expv, $sformatf("data of read from 0x%04h", addr));
            end
            "E": begin
                host_access(1'b0, addr, 32'd0, rdata, err);
                check_value({31'd0, err}, 32'd1, $sformatf("error flag of read from 0x%04h", addr));
                check_value(rdata, expv, $sformatf("data of read from 0x%04h", addr));
            end
            "S": begin
                irq_src = data[SRC_BITS-1:0];
                next_edge();
            end
            "I": check_value({29'd0, irq_timer, irq_soft, irq_ext}, expv, "irq outputs");
            "D": repeat (data) next_edge();
            default: begin
                $display("stim entry %0d has an unknown op letter '%c'", idx, stim_op[idx]);
                errors++;
            end
        endcase
    endtask

    task automatic load_stim(output bit ok);
        int          fd;
        int          n;
        int          tnum;
        string       line;
        logic [7:0]  op;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") continue;   // Column notes
            n = $sscanf(line, "%d %s %h %h %h", tnum, op, addr, data, expv);
            if (n == 5) begin
                stim_test.push_back(tnum);
                stim_op.push_back(op);
                stim_addr.push_back(addr);
                stim_data.push_back(data);
                stim_exp.push_back(expv);
            end else if (n > 0) begin
                $display("malformed line in the stimulus file: %s", line);
                $fclose(fd);
                return;
            end
        end
        $fclose(fd);
        ok = (stim_op.size() > 0);
    endtask

    task automatic report_test(input int num);
        $display("test %0d done, %0d checks, %0d errors", num, test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        bit ok;
        int cur_test;
        int d_sum;
        arst_n      = 1'b0;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        irq_src     = '0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        test_checks = 0;
        tests_run   = 0;
        void'($urandom(SEED));
        load_stim(ok);
        if (!ok) begin
            $display("TB FAILED");
            $finish;
        end else begin
            // Budget per line plus every explicit delay
            d_sum = 0;
            foreach (stim_op[i]) begin
                if (stim_op[i] == "D") d_sum += int'(stim_data[i]);
            end
            watchdog_cycles = stim_op.size() * CYCLES_PER_LINE + d_sum
                              + RESET_CYCLES + TIMEOUT_MARGIN;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DLY;
            arst_n = 1'b1;
            next_edge();
            cur_test = stim_test[0];
            foreach (stim_op[i]) begin
                if (stim_test[i] != cur_test) begin
                    report_test(cur_test);
                    cur_test = stim_test[i];
                end
                run_op(i);
            end
            report_test(cur_test);
            $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    // Watchdog armed once the stim length is known
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog fired, the run timed out after %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/irq_subsys_pkg.sv
verilog/dbus_if.sv
verilog/host_bus_bridge.sv
verilog/dbus_interconnect.sv
verilog/clint.sv
verilog/plic.sv
verilog/irq_subsys_top.sv
dv/tb_clk_gen.sv
dv/tb_irq_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interrupt subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_irq_subsys

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_irq_subsys -f flist.f -o tb_irq_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verilog/clint.sv
`timescale 1ns/1ns
`default_nettype none

module clint #(
    parameter int MTIME_DIV = 1
) (
    input  logic        clk,
    input  logic        arst_n_i,

    dbus_if.clint_port  bus,

    output logic        irq_timer_o,
    output logic        irq_soft_o
);

    localparam int DIV_W = (MTIME_DIV > 1) ? $clog2(MTIME_DIV) : 1;

    logic [irq_subsys_pkg::REGION_OFS_W-1:0]  ofs;
    logic                                     wr;
    logic                                     rd;
    logic                                     tick;
    logic [DIV_W-1:0]                         div_q;
    logic [63:0]                              mtime_q;
    logic [63:0]                              mtimecmp_q;
    logic                                     msip_q;
    logic [irq_subsys_pkg::DBUS_DW-1:0]       rd_word;

    assign ofs  = bus.addr[irq_subsys_pkg::REGION_OFS_W-1:0];
    assign wr   = bus.valid && bus.sel_clint && bus.we;
    assign rd   = bus.valid && bus.sel_clint && !bus.we;
    assign tick = (div_q == DIV_W'(MTIME_DIV - 1));   // Always set when MTIME_DIV is 1

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q       <= '0;
            mtime_q     <= '0;
            mtimecmp_q  <= '1;      // Timer irq off until software sets a compare
            msip_q      <= 1'b0;
            irq_timer_o <= 1'b0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;

            // A write to mtime takes precedence over the increment
            if (wr && ofs == irq_subsys_pkg::CLINT_MTIME_LO_OFS) begin
                mtime_q[31:0] <= bus.wdata;
            end else if (wr && ofs == irq_subsys_pkg::CLINT_MTIME_HI_OFS) begin
                mtime_q[63:32] <= bus.wdata;
            end else if (tick) begin
                mtime_q <= mtime_q + 64'd1;
            end

            if (wr && ofs == irq_subsys_pkg::CLINT_MTIMECMP_LO_OFS) begin
                mtimecmp_q[31:0] <= bus.wdata;
            end
            if (wr && ofs == irq_subsys_pkg::CLINT_MTIMECMP_HI_OFS) begin
                mtimecmp_q[63:32] <= bus.wdata;
            end
            if (wr && ofs == irq_subsys_pkg::CLINT_MSIP_OFS) begin
                msip_q <= bus.wdata[0];
            end

            irq_timer_o <= (mtime_q >= mtimecmp_q);
        end
    end

    always_comb begin
        case (ofs)
            irq_subsys_pkg::CLINT_MSIP_OFS:        rd_word = {31'd0, msip_q};
            irq_subsys_pkg::CLINT_MTIMECMP_LO_OFS: rd_word = mtimecmp_q[31:0];
            irq_subsys_pkg::CLINT_MTIMECMP_HI_OFS: rd_word = mtimecmp_q[63:32];
            irq_subsys_pkg::CLINT_MTIME_LO_OFS:    rd_word = mtime_q[31:0];
            irq_subsys_pkg::CLINT_MTIME_HI_OFS:    rd_word = mtime_q[63:32];
            default:                               rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            bus.rdata_clint <= rd_word;
        end
    end

    assign irq_soft_o = msip_q;

endmodule

`default_nettype wire

//--- verilog/dbus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dbus_if (
    input logic clk
);

    logic                                valid;
    logic [irq_subsys_pkg::DBUS_AW-1:0]  addr;
    logic [irq_subsys_pkg::DBUS_DW-1:0]  wdata;
    logic                                we;

    // Peripheral selects from the address decoder
    logic                                sel_clint;
    logic                                sel_plic;

    logic [irq_subsys_pkg::DBUS_DW-1:0]  rdata_clint;
    logic [irq_subsys_pkg::DBUS_DW-1:0]  rdata_plic;
    logic [irq_subsys_pkg::DBUS_DW-1:0]  rdata;    // Muxed, one cycle after valid
    logic                                dec_err;

    modport master (input clk, output valid, addr, wdata, we, input rdata, dec_err);

    modport xbar (input clk, valid, addr, rdata_clint, rdata_plic,
                  output sel_clint, sel_plic, rdata, dec_err);

    modport clint_port (input clk, valid, addr, wdata, we, sel_clint, output rdata_clint);

    modport plic_port (input clk, valid, addr, wdata, we, sel_plic, output rdata_plic);

endinterface

`default_nettype wire

//--- verilog/dbus_interconnect.sv
`timescale 1ns/1ns
`default_nettype none

module dbus_interconnect (
    input  logic    clk,
    input  logic    arst_n_i,

    dbus_if.xbar    bus
);

    localparam int RB_HI = irq_subsys_pkg::DBUS_AW - 1;
    localparam int RB_LO = irq_subsys_pkg::REGION_OFS_W;

    irq_subsys_pkg::dbus_region_e  region;
    irq_subsys_pkg::dbus_region_e  region_q;
    logic                          valid_q;

    // Region decode on addr[15:12]
    always_comb begin
        if (bus.addr[RB_HI:RB_LO] == irq_subsys_pkg::CLINT_BASE[RB_HI:RB_LO]) begin
            region = irq_subsys_pkg::REGION_CLINT;
        end else if (bus.addr[RB_HI:RB_LO] == irq_subsys_pkg::PLIC_BASE[RB_HI:RB_LO]) begin
            region = irq_subsys_pkg::REGION_PLIC;
        end else begin
            region = irq_subsys_pkg::REGION_NONE;
        end
    end

    assign bus.sel_clint = bus.valid && (region == irq_subsys_pkg::REGION_CLINT);
    assign bus.sel_plic  = bus.valid && (region == irq_subsys_pkg::REGION_PLIC);

    // Region kept for the read mux in the cycle after valid
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= 1'b0;
            region_q <= irq_subsys_pkg::REGION_NONE;
        end else begin
            valid_q <= bus.valid;
            if (bus.valid) begin
                region_q <= region;
            end
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (valid_q) begin
            case (region_q)
                irq_subsys_pkg::REGION_CLINT: bus.rdata = bus.rdata_clint;
                irq_subsys_pkg::REGION_PLIC:  bus.rdata = bus.rdata_plic;
                default:                      bus.rdata = '0;   // Unmapped reads as zero
            endcase
        end
    end

    assign bus.dec_err = valid_q && (region_q == irq_subsys_pkg::REGION_NONE);

    sel_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(bus.sel_clint && bus.sel_plic))
        else $error("CLINT and PLIC selected together");

endmodule

`default_nettype wire

//--- verilog/host_bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module host_bus_bridge (
    input  logic                                clk,
    input  logic                                arst_n_i,

    input  logic                                host_req_i,
    input  logic                                host_we_i,
    input  logic [irq_subsys_pkg::DBUS_AW-1:0]  host_addr_i,
    input  logic [irq_subsys_pkg::DBUS_DW-1:0]  host_wdata_i,
    output logic                                host_ack_o,
    output logic [irq_subsys_pkg::DBUS_DW-1:0]  host_rdata_o,
    output logic                                host_err_o,

    dbus_if.master                              bus
);

    irq_subsys_pkg::bridge_state_e       state_q;

    logic [irq_subsys_pkg::DBUS_AW-1:0]  addr_q;
    logic [irq_subsys_pkg::DBUS_DW-1:0]  wdata_q;
    logic                                we_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= irq_subsys_pkg::BR_IDLE;
            host_ack_o <= 1'b0;
            host_err_o <= 1'b0;
        end else begin
            case (state_q)
                irq_subsys_pkg::BR_IDLE: begin
                    if (host_req_i) begin
                        state_q <= irq_subsys_pkg::BR_ACCESS;
                    end
                end
                irq_subsys_pkg::BR_ACCESS: begin
                    state_q <= irq_subsys_pkg::BR_WAIT_DATA;
                end
                irq_subsys_pkg::BR_WAIT_DATA: begin
                    host_err_o <= bus.dec_err;
                    state_q    <= irq_subsys_pkg::BR_ACK;
                end
                irq_subsys_pkg::BR_ACK: begin
                    if (!host_ack_o) begin
                        host_ack_o <= 1'b1;
                    end else if (!host_req_i) begin   // Host saw ack, close the handshake
                        host_ack_o <= 1'b0;
                        state_q    <= irq_subsys_pkg::BR_RELEASE;
                    end
                end
                irq_subsys_pkg::BR_RELEASE: begin
                    state_q <= irq_subsys_pkg::BR_IDLE;
                end
                default: state_q <= irq_subsys_pkg::BR_IDLE;
            endcase
        end
    end

    // Request capture and read data latch
    always_ff @(posedge clk) begin
        if (state_q == irq_subsys_pkg::BR_IDLE && host_req_i) begin
            addr_q  <= host_addr_i;
            wdata_q <= host_wdata_i;
            we_q    <= host_we_i;
        end
        if (state_q == irq_subsys_pkg::BR_WAIT_DATA) begin
            host_rdata_o <= bus.rdata;
        end
    end

    assign bus.valid = (state_q == irq_subsys_pkg::BR_ACCESS);
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.we    = we_q;

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!host_req_i && !host_ack_o) |=> !host_ack_o)
        else $error("host_ack_o rose without host_req_i");

    valid_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus.valid |=> !bus.valid)
        else $error("valid held for more than one cycle");

endmodule

`default_nettype wire

//--- verilog/irq_subsys_pkg.sv
`default_nettype none

package irq_subsys_pkg;

    // Bus widths, host side and internal side alike
    localparam int DBUS_AW = 16;
    localparam int DBUS_DW = 32;

    // Each region spans 4 KB, picked by addr[15:12]
    localparam int REGION_OFS_W = 12;

    localparam logic [DBUS_AW-1:0] CLINT_BASE = 16'h0000;
    localparam logic [DBUS_AW-1:0] PLIC_BASE  = 16'h1000;

    // CLINT word offsets
    localparam logic [REGION_OFS_W-1:0] CLINT_MSIP_OFS        = 12'h000;
    localparam logic [REGION_OFS_W-1:0] CLINT_MTIMECMP_LO_OFS = 12'h008;
    localparam logic [REGION_OFS_W-1:0] CLINT_MTIMECMP_HI_OFS = 12'h00C;
    localparam logic [REGION_OFS_W-1:0] CLINT_MTIME_LO_OFS    = 12'h010;
    localparam logic [REGION_OFS_W-1:0] CLINT_MTIME_HI_OFS    = 12'h014;

    // PLIC word offsets, priority of source n sits at PLIC_PRIO_OFS + 4n
    localparam logic [REGION_OFS_W-1:0] PLIC_PRIO_OFS   = 12'h000;
    localparam logic [REGION_OFS_W-1:0] PLIC_PEND_OFS   = 12'h080;
    localparam logic [REGION_OFS_W-1:0] PLIC_EN_OFS     = 12'h100;
    localparam logic [REGION_OFS_W-1:0] PLIC_THRESH_OFS = 12'h200;
    localparam logic [REGION_OFS_W-1:0] PLIC_CLAIM_OFS  = 12'h204;

    localparam int PLIC_PRIO_W = 3;

    typedef enum logic [1:0] {
        REGION_CLINT,
        REGION_PLIC,
        REGION_NONE
    } dbus_region_e;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_ACCESS,      // Single valid cycle
        BR_WAIT_DATA,
        BR_ACK,
        BR_RELEASE
    } bridge_state_e;

endpackage

`default_nettype wire

//--- verilog/irq_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module irq_subsys_top #(
    parameter int SRC_COUNT = 4,
    parameter int MTIME_DIV = 1
) (
    input  logic                                clk,
    input  logic                                arst_n_i,

    // Host four-phase port
    input  logic                                host_req_i,
    input  logic                                host_we_i,
    input  logic [irq_subsys_pkg::DBUS_AW-1:0]  host_addr_i,
    input  logic [irq_subsys_pkg::DBUS_DW-1:0]  host_wdata_i,
    output logic                                host_ack_o,
    output logic [irq_subsys_pkg::DBUS_DW-1:0]  host_rdata_o,
    output logic                                host_err_o,

    input  logic [SRC_COUNT-1:0]                irq_src_i,
    output logic                                irq_timer_o,
    output logic                                irq_soft_o,
    output logic                                irq_ext_o
);

    dbus_if i_dbus (.clk(clk));

    host_bus_bridge i_bridge (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .host_err_o   (host_err_o),
        .bus          (i_dbus.master)
    );

    dbus_interconnect i_xbar (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (i_dbus.xbar)
    );

    clint #(
        .MTIME_DIV (MTIME_DIV)
    ) i_clint (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus         (i_dbus.clint_port),
        .irq_timer_o (irq_timer_o),
        .irq_soft_o  (irq_soft_o)
    );

    plic #(
        .SRC_COUNT (SRC_COUNT)
    ) i_plic (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .bus       (i_dbus.plic_port),
        .irq_src_i (irq_src_i),
        .irq_ext_o (irq_ext_o)      // Single target
    );

endmodule

`default_nettype wire

//--- verilog/plic.sv
`timescale 1ns/1ns
`default_nettype none

module plic #(
    parameter int SRC_COUNT = 4
) (
    input  logic                  clk,
    input  logic                  arst_n_i,

    dbus_if.plic_port             bus,

    input  logic [SRC_COUNT-1:0]  irq_src_i,
    output logic                  irq_ext_o
);

    localparam int ID_W   = $clog2(SRC_COUNT + 1);
    localparam int PRIO_W = irq_subsys_pkg::PLIC_PRIO_W;

    logic [irq_subsys_pkg::REGION_OFS_W-1:0]  ofs;
    logic                                     wr;
    logic                                     rd;
    logic                                     prio_hit;
    logic                                     claim_rd;
    logic                                     compl_wr;
    logic [PRIO_W-1:0]                        prio_q [1:SRC_COUNT];
    logic [PRIO_W-1:0]                        thresh_q;
    logic [SRC_COUNT:1]                       src;
    logic [SRC_COUNT:1]                       pend_q;
    logic [SRC_COUNT:1]                       en_q;
    logic [SRC_COUNT:1]                       busy_q;      // Claimed, not yet completed
    logic [SRC_COUNT:1]                       claim_vec;
    logic [SRC_COUNT:1]                       compl_vec;
    logic [ID_W-1:0]                          best_id;
    logic [PRIO_W-1:0]                        best_prio;
    logic [irq_subsys_pkg::DBUS_DW-1:0]       rd_word;

    assign ofs      = bus.addr[irq_subsys_pkg::REGION_OFS_W-1:0];
    assign wr       = bus.valid && bus.sel_plic && bus.we;
    assign rd       = bus.valid && bus.sel_plic && !bus.we;
    assign prio_hit = (ofs[11:7] == irq_subsys_pkg::PLIC_PRIO_OFS[11:7]);
    assign claim_rd = rd && (ofs == irq_subsys_pkg::PLIC_CLAIM_OFS);
    assign compl_wr = wr && (ofs == irq_subsys_pkg::PLIC_CLAIM_OFS);
    assign src      = irq_src_i;    // Source n on bit n

    // Highest priority above threshold wins, ties go to the lower ID
    always_comb begin
        best_id   = '0;
        best_prio = thresh_q;
        for (int n = 1; n <= SRC_COUNT; n++) begin
            if (pend_q[n] && en_q[n] && prio_q[n] > best_prio) begin
                best_id   = ID_W'(n);
                best_prio = prio_q[n];
            end
        end
    end

    always_comb begin
        claim_vec = '0;
        compl_vec = '0;
        for (int n = 1; n <= SRC_COUNT; n++) begin
            claim_vec[n] = claim_rd && (best_id == ID_W'(n));
            compl_vec[n] = compl_wr && (bus.wdata[ID_W-1:0] == ID_W'(n));
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int n = 1; n <= SRC_COUNT; n++) begin
                prio_q[n] <= '0;
            end
            thresh_q  <= '0;
            pend_q    <= '0;
            en_q      <= '0;
            busy_q    <= '0;
            irq_ext_o <= 1'b0;
        end else begin
            for (int n = 1; n <= SRC_COUNT; n++) begin
                if (wr && prio_hit && ofs[6:2] == 5'(n)) begin
                    prio_q[n] <= bus.wdata[PRIO_W-1:0];
                end
            end
            if (wr && ofs == irq_subsys_pkg::PLIC_EN_OFS) begin
                en_q <= bus.wdata[SRC_COUNT:1];
            end
            if (wr && ofs == irq_subsys_pkg::PLIC_THRESH_OFS) begin
                thresh_q <= bus.wdata[PRIO_W-1:0];
            end

            // Gateway holds off a source while its claim is outstanding
            pend_q    <= (pend_q | (src & ~busy_q)) & ~claim_vec;
            busy_q    <= (busy_q | claim_vec) & ~compl_vec;
            irq_ext_o <= (best_id != '0);
        end
    end

    always_comb begin
        rd_word = '0;
        if (prio_hit) begin
            for (int n = 1; n <= SRC_COUNT; n++) begin
                if (ofs[6:2] == 5'(n)) rd_word[PRIO_W-1:0] = prio_q[n];
            end
        end else begin
            case (ofs)
                irq_subsys_pkg::PLIC_PEND_OFS:   rd_word[SRC_COUNT:1] = pend_q;
                irq_subsys_pkg::PLIC_EN_OFS:     rd_word[SRC_COUNT:1] = en_q;
                irq_subsys_pkg::PLIC_THRESH_OFS: rd_word[PRIO_W-1:0]  = thresh_q;
                irq_subsys_pkg::PLIC_CLAIM_OFS:  rd_word[ID_W-1:0]    = best_id;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            bus.rdata_plic <= rd_word;
        end
    end

    claim_id_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        claim_rd |=> (bus.rdata_plic <= irq_subsys_pkg::DBUS_DW'(SRC_COUNT)))
        else $error("Claim returned an ID above SRC_COUNT");

endmodule

`default_nettype wire
